/* src/sata_phy_pkg.sv */
// --------------------
// sata phy shared definitions
// primitive codes, generation codes, timing constants
// and the link controller state type
// --------------------
`default_nettype none

package sata_phy_pkg;

    // --------------------
    // dwords and primitives
    localparam int DWORD_W = 32;                                    // tx/rx dword width

    localparam logic [DWORD_W - 1 : 0] ALIGN_PRIM = 32'h7B4A_4ABC;  // K28.5 D10.2 D10.2 D27.3
    localparam logic [DWORD_W - 1 : 0] SYNC_PRIM  = 32'hB5B5_957C;  // K28.3 D21.4 D21.5 D21.5
    localparam logic [DWORD_W - 1 : 0] DIAL_DATA  = 32'h4A4A_4A4A;  // D10.2 dial tone

    localparam logic DWORD_IS_PRIM = 1'b1;  // k-flag on byte 0
    localparam logic DWORD_IS_DATA = 1'b0;

    // --------------------
    // generations
    localparam int GEN_W = 2;

    localparam logic [GEN_W - 1 : 0] SATA_GEN1 = 2'd1; // 1.5 Gb/s
    localparam logic [GEN_W - 1 : 0] SATA_GEN2 = 2'd2; // 3.0 Gb/s
    localparam logic [GEN_W - 1 : 0] SATA_GEN3 = 2'd3; // 6.0 Gb/s

    // --------------------
    // timing
    localparam int TIMEOUT_CYCLES = 200;                        // scaled down for sim
    localparam int TIMEOUT_W      = $clog2(TIMEOUT_CYCLES + 1);

    localparam int ALIGN_PERIOD = 256;                          // two ALIGNs per period
    localparam int ALIGN_W      = $clog2(ALIGN_PERIOD);

    localparam int LINKUP_DELAY = 31;                           // settle before linkup

    // --------------------
    // link controller states
    typedef enum logic [3 : 0] {
        st_idle,
        st_send_comreset,   // single cycle cominit pulse
        st_suspend_comreset,
        st_wait_cominit,
        st_send_comwake,    // single cycle comwake pulse
        st_suspend_comwake,
        st_wait_comwake,
        st_wait_oobfinish,
        st_send_dial,       // dial tone until ALIGN
        st_request_recfg,
        st_wait_recfg,
        st_send_align,      // ALIGN until SYNC
        st_link_ready
    } link_state_t;

endpackage

`default_nettype wire

/* src/sata_rx_prim_detect.sv */
// --------------------
// receive primitive detector
// registers the rx dword and status, flags ALIGN,
// SYNC and a healthy receiver one cycle later
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sata_rx_prim_detect import sata_phy_pkg::*; (
    input  wire logic                   tx_reset,           // clock
    input  wire logic                   tx_clk,             // async reset, active high

    input  wire logic [DWORD_W - 1 : 0] i_rx_data,
    input  wire logic                   i_rx_datak,
    input  wire logic                   i_rx_syncstatus,    // lanes already reduced
    input  wire logic                   i_rx_signaldetect,

    output logic                        o_align_seen,
    output logic                        o_sync_seen,
    output logic                        o_link_ok
);

    logic [DWORD_W - 1 : 0] rx_data_q;      // received payload dword
    logic                   rx_datak_q;
    logic                   rx_sync_q;
    logic                   rx_sigdet_q;
    logic                   is_prim;

    // --------------------
    // input registers
    always_ff @(posedge tx_reset) begin
        rx_data_q <= i_rx_data;
    end

    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            rx_datak_q  <= DWORD_IS_DATA;
            rx_sync_q   <= 1'b0;
            rx_sigdet_q <= 1'b0;
        end else begin
            rx_datak_q  <= i_rx_datak;
            rx_sync_q   <= i_rx_syncstatus;
            rx_sigdet_q <= i_rx_signaldetect;
        end
    end

    // --------------------
    // decode
    assign is_prim = (rx_datak_q == DWORD_IS_PRIM);

    // ALIGN only counts once the lanes are word locked
    assign o_align_seen = is_prim && (rx_data_q == ALIGN_PRIM) && rx_sync_q;
    assign o_sync_seen  = is_prim && (rx_data_q == SYNC_PRIM);
    assign o_link_ok    = rx_sigdet_q && rx_sync_q;    // drop either and the link is gone

endmodule

`default_nettype wire

/* src/sata_link_fsm.sv */
// --------------------
// link bring-up controller
// OOB sequence, speed negotiation with timeouts
// and generation stepping on failed dial
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sata_link_fsm import sata_phy_pkg::*; (
    input  wire logic                   tx_reset,       // clock
    input  wire logic                   tx_clk,         // async reset, active high

    input  wire logic                   i_phy_locked,
    input  wire logic                   i_oob_ready,    // OOB coder idle
    input  wire logic                   i_rx_cominit,   // strobes from OOB decoder
    input  wire logic                   i_rx_comwake,
    input  wire logic                   i_rx_oobfinish,
    input  wire logic                   i_align_seen,
    input  wire logic                   i_sync_seen,
    input  wire logic                   i_link_ok,
    input  wire logic                   i_recfg_ready,  // one-cycle accept

    output logic                        o_tx_cominit,
    output logic                        o_tx_comwake,
    output logic                        o_tx_oobfinish,
    output logic                        o_dial_sel,
    output logic                        o_link_ready,
    output logic                        o_recfg_request,
    output logic [GEN_W - 1 : 0]        o_recfg_gen,
    output logic [GEN_W - 1 : 0]        o_sata_gen
);

    link_state_t            state;
    link_state_t            state_nxt;

    logic [TIMEOUT_W - 1 : 0] timeout_cnt;
    logic                   timeout_run;    // state has a timeout
    logic                   timeout_hit;

    logic [GEN_W - 1 : 0]   cur_gen;        // running generation
    logic [GEN_W - 1 : 0]   req_gen;        // generation asked for next
    logic                   recfg_accept;

    // --------------------
    // state decode
    assign o_tx_cominit    = (state == st_send_comreset);
    assign o_tx_comwake    = (state == st_send_comwake);
    assign o_dial_sel      = (state == st_send_dial);
    assign o_link_ready    = (state == st_link_ready);
    assign o_recfg_request = (state == st_request_recfg);

    // OOB phase is over from dial onwards
    assign o_tx_oobfinish = (state == st_send_dial) || (state == st_send_align) ||
                            (state == st_link_ready);

    assign timeout_run = (state == st_wait_cominit)   || (state == st_wait_comwake) ||
                         (state == st_wait_oobfinish) || (state == st_send_dial)    ||
                         (state == st_wait_recfg)     || (state == st_send_align);

    assign timeout_hit  = (timeout_cnt == TIMEOUT_W'(TIMEOUT_CYCLES - 1));
    assign recfg_accept = o_recfg_request && i_recfg_ready;

    // --------------------
    // next state
    always_comb begin
        state_nxt = state;  // hold by default
        case (state)
            st_idle:
                if (i_phy_locked) state_nxt = st_send_comreset;
            st_send_comreset:
                state_nxt = st_suspend_comreset;
            st_suspend_comreset:
                if (i_oob_ready) state_nxt = st_wait_cominit;
            st_wait_cominit:
                if (i_rx_cominit)     state_nxt = st_send_comwake;
                else if (timeout_hit) state_nxt = st_idle;
            st_send_comwake:
                state_nxt = st_suspend_comwake;
            st_suspend_comwake:
                if (i_oob_ready) state_nxt = st_wait_comwake;
            st_wait_comwake:
                if (i_rx_comwake)     state_nxt = st_wait_oobfinish;
                else if (timeout_hit) state_nxt = st_idle;
            st_wait_oobfinish:
                if (i_rx_oobfinish)   state_nxt = st_send_dial;
                else if (timeout_hit) state_nxt = st_idle;
            st_send_dial:
                if (i_align_seen)     state_nxt = st_send_align;
                else if (timeout_hit) state_nxt = st_request_recfg; // try next speed
            st_request_recfg:
                if (i_recfg_ready) state_nxt = st_wait_recfg;
            st_wait_recfg:
                if (timeout_hit) state_nxt = st_idle;   // give the PLL time to settle
            st_send_align:
                if (i_sync_seen)      state_nxt = st_link_ready;
                else if (timeout_hit) state_nxt = st_idle;
            st_link_ready:
                if (!i_link_ok) state_nxt = st_idle;
            default:
                state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------
    // timeout counter
    // restarts on every state change
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            timeout_cnt <= '0;
        end else if (timeout_run && (state_nxt == state)) begin
            timeout_cnt <= timeout_cnt + 1'b1;
        end else begin
            timeout_cnt <= '0;
        end
    end

    // --------------------
    // generation registers
    // step 3 -> 2 -> 1 -> 3 on accept
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            cur_gen <= SATA_GEN3;
            req_gen <= SATA_GEN2;
        end else if (recfg_accept) begin
            cur_gen <= (cur_gen == SATA_GEN1) ? SATA_GEN3 : cur_gen - 1'b1;
            req_gen <= (req_gen == SATA_GEN1) ? SATA_GEN3 : req_gen - 1'b1;
        end
    end

    assign o_recfg_gen = req_gen;
    assign o_sata_gen  = o_link_ready ? cur_gen : '0;   // only valid with link up

    // --------------------
    // assertions
    // every counting state leaves before the bound
    a_timeout_bound: assert property (
        @(posedge tx_reset) disable iff (tx_clk)
        timeout_cnt < TIMEOUT_W'(TIMEOUT_CYCLES)
    ) else $error("timeout counter ran past its bound");

    // the generation taken on accept is the one that was requested
    a_recfg_gen: assert property (
        @(posedge tx_reset) disable iff (tx_clk)
        recfg_accept |=> (cur_gen == $past(req_gen))
    ) else $error("accepted generation differs from the requested one");

endmodule

`default_nettype wire

/* src/sata_tx_word_mux.sv */
// --------------------
// transmit word stage
// picks dial, user data or ALIGN, inserts two ALIGNs
// per period and raises linkup after settling
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sata_tx_word_mux import sata_phy_pkg::*; (
    input  wire logic                   tx_reset,       // clock
    input  wire logic                   tx_clk,         // async reset, active high

    input  wire logic                   i_dial_sel,
    input  wire logic                   i_link_ready,

    input  wire logic [DWORD_W - 1 : 0] i_tx_data,
    input  wire logic                   i_tx_datak,

    output logic [DWORD_W - 1 : 0]      o_tx_data,
    output logic                        o_tx_datak,
    output logic                        o_tx_ready,     // low during ALIGN insertion
    output logic                        o_linkup
);

    logic [ALIGN_W - 1 : 0]                 align_cnt;
    logic                                   align_reg;
    logic [$clog2(LINKUP_DELAY + 1) - 1 : 0] linkup_cnt;
    logic                                   linkup_reg;

    // --------------------
    // ALIGN insertion
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            align_cnt <= '0;
        end else if (i_link_ready) begin
            align_cnt <= align_cnt + 1'b1;  // wraps every ALIGN_PERIOD
        end else begin
            align_cnt <= '0;
        end
    end

    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            align_reg <= 1'b0;
        end else begin
            align_reg <= i_link_ready && ((align_cnt == 0) || (align_cnt == 1));
        end
    end

    assign o_tx_ready = ~align_reg;

    // --------------------
    // tx dword register
    // dial first, then user data, otherwise ALIGN
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            o_tx_data  <= '0;
            o_tx_datak <= 1'b0;
        end else if (i_dial_sel) begin
            o_tx_data  <= DIAL_DATA;
            o_tx_datak <= DWORD_IS_DATA;
        end else if (i_link_ready && !align_reg) begin
            o_tx_data  <= i_tx_data;
            o_tx_datak <= i_tx_datak;
        end else begin
            o_tx_data  <= ALIGN_PRIM;   // idle fill and inserted ALIGNs
            o_tx_datak <= DWORD_IS_PRIM;
        end
    end

    // --------------------
    // linkup
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            linkup_cnt <= '0;
        end else if (i_link_ready) begin
            linkup_cnt <= linkup_cnt + (linkup_cnt != LINKUP_DELAY);  // saturates
        end else begin
            linkup_cnt <= '0;
        end
    end

    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            linkup_reg <= 1'b0;
        end else begin
            linkup_reg <= i_link_ready && (linkup_cnt == LINKUP_DELAY);
        end
    end

    assign o_linkup = linkup_reg;

    // back-pressure never longer than the two ALIGN dwords
    a_ready_gap: assert property (
        @(posedge tx_reset) disable iff (tx_clk)
        $fell(o_tx_ready) |-> ##2 o_tx_ready
    ) else $error("tx ready low for more than 2 cycles");

endmodule

`default_nettype wire

/* src/sata_phy_link.sv */
// --------------------
// sata phy link top
// rx primitive detect -> link controller -> tx word stage
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sata_phy_link import sata_phy_pkg::*; (
    input  wire logic                   tx_reset,           // clock
    input  wire logic                   tx_clk,             // async reset, active high

    // transceiver and OOB status
    input  wire logic                   i_phy_locked,
    input  wire logic                   i_oob_ready,
    input  wire logic                   i_rx_cominit,
    input  wire logic                   i_rx_comwake,
    input  wire logic                   i_rx_oobfinish,
    input  wire logic                   i_rx_signaldetect,
    input  wire logic                   i_rx_syncstatus,

    // received dword
    input  wire logic [DWORD_W - 1 : 0] i_rx_data,
    input  wire logic                   i_rx_datak,

    // reconfiguration
    input  wire logic                   i_recfg_ready,
    output logic                        o_recfg_request,
    output logic [GEN_W - 1 : 0]        o_recfg_gen,
    output logic [GEN_W - 1 : 0]        o_sata_gen,

    // OOB commands
    output logic                        o_tx_cominit,
    output logic                        o_tx_comwake,
    output logic                        o_tx_oobfinish,

    // user tx side
    input  wire logic [DWORD_W - 1 : 0] i_tx_data,
    input  wire logic                   i_tx_datak,
    output logic [DWORD_W - 1 : 0]      o_tx_data,
    output logic                        o_tx_datak,
    output logic                        o_tx_ready,
    output logic                        o_linkup
);

    logic align_seen;
    logic sync_seen;
    logic link_ok;
    logic dial_sel;
    logic link_ready;

    sata_rx_prim_detect u_rx_prim_detect (
        .tx_reset           (tx_reset),
        .tx_clk             (tx_clk),
        .i_rx_data          (i_rx_data),
        .i_rx_datak         (i_rx_datak),
        .i_rx_syncstatus    (i_rx_syncstatus),
        .i_rx_signaldetect  (i_rx_signaldetect),
        .o_align_seen       (align_seen),
        .o_sync_seen        (sync_seen),
        .o_link_ok          (link_ok)
    );

    sata_link_fsm u_link_fsm (
        .tx_reset           (tx_reset),
        .tx_clk             (tx_clk),
        .i_phy_locked       (i_phy_locked),
        .i_oob_ready        (i_oob_ready),
        .i_rx_cominit       (i_rx_cominit),
        .i_rx_comwake       (i_rx_comwake),
        .i_rx_oobfinish     (i_rx_oobfinish),
        .i_align_seen       (align_seen),
        .i_sync_seen        (sync_seen),
        .i_link_ok          (link_ok),
        .i_recfg_ready      (i_recfg_ready),
        .o_tx_cominit       (o_tx_cominit),
        .o_tx_comwake       (o_tx_comwake),
        .o_tx_oobfinish     (o_tx_oobfinish),
        .o_dial_sel         (dial_sel),
        .o_link_ready       (link_ready),
        .o_recfg_request    (o_recfg_request),
        .o_recfg_gen        (o_recfg_gen),
        .o_sata_gen         (o_sata_gen)
    );

    sata_tx_word_mux u_tx_word_mux (
        .tx_reset           (tx_reset),
        .tx_clk             (tx_clk),
        .i_dial_sel         (dial_sel),
        .i_link_ready       (link_ready),
        .i_tx_data          (i_tx_data),
        .i_tx_datak         (i_tx_datak),
        .o_tx_data          (o_tx_data),
        .o_tx_datak         (o_tx_datak),
        .o_tx_ready         (o_tx_ready),
        .o_linkup           (o_linkup)
    );

endmodule

`default_nettype wire

/* test/sata_phy_tb_tasks.svh */
// --------------------
// sata phy testbench tasks
// compare, bounded waits, reset and the six tests
// --------------------
`ifndef SATA_PHY_TB_TASKS_SVH
`define SATA_PHY_TB_TASKS_SVH

task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERROR %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
endtask

function automatic logic [31:0] probe(input int sel);
    case (sel)
        SEL_LINKUP:  probe = {31'd0, o_linkup};
        SEL_TX_DATA: probe = o_tx_data;
        SEL_RECFG:   probe = {31'd0, o_recfg_request};
        SEL_COMWAKE: probe = {31'd0, o_tx_comwake};
        default:     probe = cominit_cnt;
    endcase
endfunction

// checks the current cycle first, then steps on negedges
task automatic wait_for(input string what, input int sel, input logic [31:0] val,
                        input int limit);
    int n;
    n = 0;
    while ((probe(sel) !== val) && (n < limit)) begin
        @(negedge tx_reset);
        n++;
    end
    if (probe(sel) !== val) begin
        errors++;
        $display("%s: gave up after %0d cycles waiting for %s", test_name, limit, what);
    end
endtask

task automatic apply_reset();
    @(posedge tx_reset);
    tx_clk            <= 1'b1;
    i_phy_locked      <= 1'b0;
    i_rx_data         <= '0;
    i_rx_datak        <= 1'b0;
    i_rx_syncstatus   <= 1'b1;
    i_rx_signaldetect <= 1'b1;
    i_tx_data         <= '0;
    i_tx_datak        <= 1'b0;
    repeat (2) @(posedge tx_reset);
    tx_clk <= 1'b0;
    @(negedge tx_reset);
endtask

task automatic start_test(input string name);
    test_name = name;
    err_base  = errors;
endtask

task automatic finish_test();
    tests++;
    $display("%s finished, %0d errors", test_name, errors - err_base);
endtask

// --------------------
// dial to linkup with the device answering ALIGN then SYNC
task automatic complete_negotiation(input int dial_limit);
    wait_for("dial pattern", SEL_TX_DATA, DIAL_DATA, dial_limit);
    compare("dial k-flag", DWORD_IS_DATA, o_tx_datak);
    compare("oob finish", 1, o_tx_oobfinish);
    @(posedge tx_reset);
    i_rx_data  <= ALIGN_PRIM;
    i_rx_datak <= DWORD_IS_PRIM;
    @(negedge tx_reset);
    wait_for("ALIGN on tx", SEL_TX_DATA, ALIGN_PRIM, OOB_WAIT);
    compare("align k-flag", DWORD_IS_PRIM, o_tx_datak);
    @(posedge tx_reset);
    i_rx_data <= SYNC_PRIM;
    @(negedge tx_reset);
    wait_for("linkup", SEL_LINKUP, 1, LINKUP_DELAY + OOB_WAIT);
endtask

task automatic check_reset_state();
    start_test("reset_state");
    apply_reset();
    compare("linkup", 0, o_linkup);
    compare("cominit", 0, o_tx_cominit);
    compare("oob finish", 0, o_tx_oobfinish);
    compare("recfg request", 0, o_recfg_request);
    compare("tx data", 0, o_tx_data);
    compare("sata gen", 0, o_sata_gen);
    compare("tx ready", 1, o_tx_ready);
    finish_test();
endtask

task automatic bring_link_up();
    int base;
    start_test("bring_up");
    base = cominit_cnt;
    @(posedge tx_reset);
    i_phy_locked <= 1'b1;
    @(negedge tx_reset);
    wait_for("cominit pulse", SEL_COMINIT, base + 1, OOB_WAIT);
    wait_for("comwake pulse", SEL_COMWAKE, 1, OOB_WAIT);
    complete_negotiation(OOB_WAIT);
    compare("sata gen", SATA_GEN3, o_sata_gen);
    finish_test();
endtask

task automatic stream_user_data();
    logic [DWORD_W - 1 : 0] word;
    logic [DWORD_W - 1 : 0] exp_data;
    logic                   exp_k;
    logic                   ready_now;
    int                     low_cnt;
    start_test("data_align");
    low_cnt  = 0;
    exp_data = '0;
    exp_k    = 1'b0;
    word     = $random(seed);
    @(posedge tx_reset);
    i_tx_data  <= word;
    i_tx_datak <= DWORD_IS_DATA;
    for (int i = 0; i <= ALIGN_PERIOD; i++) begin
        @(negedge tx_reset);
        if (i > 0) begin
            compare("tx dword", exp_data, o_tx_data);
            compare("tx k-flag", exp_k, o_tx_datak);
        end
        ready_now = o_tx_ready;
        if (i < ALIGN_PERIOD && !ready_now) low_cnt++;
        exp_data = ready_now ? word : ALIGN_PRIM;     // ALIGN takes the refused slot
        exp_k    = ready_now ? DWORD_IS_DATA : DWORD_IS_PRIM;
        @(posedge tx_reset);
        if (ready_now) begin
            word = $random(seed);
            i_tx_data <= word;                        // else hold the offered word
        end
    end
    compare("ready low cycles", 2, low_cnt);
    @(negedge tx_reset);
    finish_test();
endtask

task automatic expect_oob_timeout();
    int base;
    start_test("timeout");
    apply_reset();
    answer_cominit = 1'b0;
    base = cominit_cnt;
    @(posedge tx_reset);
    i_phy_locked <= 1'b1;
    @(negedge tx_reset);
    wait_for("first cominit", SEL_COMINIT, base + 1, OOB_WAIT);
    wait_for("repeated cominit", SEL_COMINIT, base + 2, LONG_WAIT);
    compare("linkup", 0, o_linkup);
    answer_cominit = 1'b1;
    finish_test();
endtask

task automatic step_speed_down();
    start_test("speed_step");
    apply_reset();
    @(posedge tx_reset);
    i_phy_locked <= 1'b1;
    @(negedge tx_reset);
    wait_for("dial pattern", SEL_TX_DATA, DIAL_DATA, OOB_WAIT);
    wait_for("recfg request", SEL_RECFG, 1, LONG_WAIT);
    compare("recfg gen", SATA_GEN2, o_recfg_gen);
    wait_for("dial to end", SEL_TX_DATA, ALIGN_PRIM, OOB_WAIT);
    complete_negotiation(LONG_WAIT);
    compare("sata gen", SATA_GEN2, o_sata_gen);
    compare("next recfg gen", SATA_GEN1, o_recfg_gen);
    finish_test();
endtask

task automatic lose_link();
    int base;
    start_test("link_loss");
    base = cominit_cnt;
    @(posedge tx_reset);
    i_rx_signaldetect <= 1'b0;
    @(negedge tx_reset);
    wait_for("linkup to drop", SEL_LINKUP, 0, OOB_WAIT);
    compare("tx dword", ALIGN_PRIM, o_tx_data);
    compare("tx k-flag", DWORD_IS_PRIM, o_tx_datak);
    wait_for("new cominit", SEL_COMINIT, base + 1, OOB_WAIT);
    @(posedge tx_reset);
    i_rx_signaldetect <= 1'b1;
    @(negedge tx_reset);
    finish_test();
endtask

`endif

/* test/sata_phy_tb.sv */
// --------------------
// sata phy link testbench
// clock, reset, DUT, device model for OOB
// and reconfiguration, directed test sequence
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sata_phy_tb import sata_phy_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int OOB_WAIT   = 20;                       // short handshake bound
    localparam int LONG_WAIT  = 2 * TIMEOUT_CYCLES + 20;  // covers one full timeout

    // probe selectors for the wait helper
    localparam int SEL_LINKUP  = 0;
    localparam int SEL_TX_DATA = 1;
    localparam int SEL_RECFG   = 2;
    localparam int SEL_COMWAKE = 3;
    localparam int SEL_COMINIT = 4;  // counts pulses rather than the level

    logic                   tx_reset;   // clock
    logic                   tx_clk;     // reset

    logic                   i_phy_locked;
    logic                   i_oob_ready;
    logic                   i_rx_cominit;
    logic                   i_rx_comwake;
    logic                   i_rx_oobfinish;
    logic                   i_rx_signaldetect;
    logic                   i_rx_syncstatus;
    logic [DWORD_W - 1 : 0] i_rx_data;
    logic                   i_rx_datak;
    logic                   i_recfg_ready;
    logic [DWORD_W - 1 : 0] i_tx_data;
    logic                   i_tx_datak;

    logic                   o_recfg_request;
    logic [GEN_W - 1 : 0]   o_recfg_gen;
    logic [GEN_W - 1 : 0]   o_sata_gen;
    logic                   o_tx_cominit;
    logic                   o_tx_comwake;
    logic                   o_tx_oobfinish;
    logic [DWORD_W - 1 : 0] o_tx_data;
    logic                   o_tx_datak;
    logic                   o_tx_ready;
    logic                   o_linkup;

    int     errors      = 0;
    int     checks      = 0;
    int     tests       = 0;
    int     err_base    = 0;
    int     cominit_cnt = 0;    // cominit pulses seen so far
    bit     answer_cominit;     // device model replies to COMRESET
    string  test_name;
    integer seed;

    sata_phy_link i_dut (
        .tx_reset           (tx_reset),
        .tx_clk             (tx_clk),
        .i_phy_locked       (i_phy_locked),
        .i_oob_ready        (i_oob_ready),
        .i_rx_cominit       (i_rx_cominit),
        .i_rx_comwake       (i_rx_comwake),
        .i_rx_oobfinish     (i_rx_oobfinish),
        .i_rx_signaldetect  (i_rx_signaldetect),
        .i_rx_syncstatus    (i_rx_syncstatus),
        .i_rx_data          (i_rx_data),
        .i_rx_datak         (i_rx_datak),
        .i_recfg_ready      (i_recfg_ready),
        .o_recfg_request    (o_recfg_request),
        .o_recfg_gen        (o_recfg_gen),
        .o_sata_gen         (o_sata_gen),
        .o_tx_cominit       (o_tx_cominit),
        .o_tx_comwake       (o_tx_comwake),
        .o_tx_oobfinish     (o_tx_oobfinish),
        .i_tx_data          (i_tx_data),
        .i_tx_datak         (i_tx_datak),
        .o_tx_data          (o_tx_data),
        .o_tx_datak         (o_tx_datak),
        .o_tx_ready         (o_tx_ready),
        .o_linkup           (o_linkup)
    );

    initial begin
        tx_reset = 1'b0;
        forever #(CLK_PERIOD / 2) tx_reset = ~tx_reset;
    end

    // --------------------
    // device model
    // strobes land once the FSM sits in the matching wait state
    always begin
        @(negedge tx_reset);
        if (o_tx_cominit && answer_cominit) begin
            repeat (2) @(posedge tx_reset);     // send + suspend
            i_rx_cominit <= 1'b1;
            @(posedge tx_reset);
            i_rx_cominit <= 1'b0;
        end else if (o_tx_comwake) begin
            repeat (2) @(posedge tx_reset);
            i_rx_comwake <= 1'b1;
            @(posedge tx_reset);
            i_rx_comwake   <= 1'b0;
            i_rx_oobfinish <= 1'b1;             // OOB done right after comwake
            @(posedge tx_reset);
            i_rx_oobfinish <= 1'b0;
        end else if (o_recfg_request) begin
            @(posedge tx_reset);
            i_recfg_ready <= 1'b1;              // single accept strobe
            @(posedge tx_reset);
            i_recfg_ready <= 1'b0;
        end
    end

    always @(negedge tx_reset) begin
        if (o_tx_cominit) cominit_cnt <= cominit_cnt + 1;
    end

    `include "sata_phy_tb_tasks.svh"

    // --------------------
    // test sequence
    initial begin
        seed              = 39297;
        answer_cominit    = 1'b1;
        tx_clk            = 1'b1;   // reset held from time zero
        i_phy_locked      = 1'b0;
        i_oob_ready       = 1'b1;
        i_rx_cominit      = 1'b0;
        i_rx_comwake      = 1'b0;
        i_rx_oobfinish    = 1'b0;
        i_rx_signaldetect = 1'b1;
        i_rx_syncstatus   = 1'b1;
        i_rx_data         = '0;
        i_rx_datak        = 1'b0;
        i_recfg_ready     = 1'b0;
        i_tx_data         = '0;
        i_tx_datak        = 1'b0;

        check_reset_state();
        bring_link_up();
        stream_user_data();
        expect_oob_timeout();
        step_speed_down();
        lose_link();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+test
src/sata_phy_pkg.sv
src/sata_rx_prim_detect.sv
src/sata_link_fsm.sv
src/sata_tx_word_mux.sv
src/sata_phy_link.sv
test/sata_phy_tb.sv
